// ==== files.f ====
umi_pkg.sv
umi_endpoint.sv
la_spram.sv
umi_mem_agent.sv
tb_clkgen.sv
tb_umi_mem_agent.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the UMI memory agent testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f files.f --top-module tb_umi_mem_agent \
      -o sim_umi_mem_agent; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_umi_mem_agent)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Everything OK$" <<< "$out"; then
   exit 0
else
   exit 1
fi

// ==== tb_umi_mem_agent.sv ====
// UMI memory agent testbench
`timescale 1ns/10ps

module tb_umi_mem_agent;

   localparam int DW       = 256;
   localparam int AW       = 64;
   localparam int CW       = 32;
   localparam int RAMDEPTH = 64;
   localparam int NB       = DW/8;              // Bytes per row
   localparam int OW       = $clog2(NB);        // Offset bits
   localparam int RW       = $clog2(RAMDEPTH);  // Row bits
   localparam int MARGIN   = 1000;              // Watchdog slack, cycles

   logic          clk;
   logic          nreset;
   logic          udev_req_valid;
   logic [CW-1:0] udev_req_cmd;
   logic [AW-1:0] udev_req_dstaddr;
   logic [AW-1:0] udev_req_srcaddr;
   logic [DW-1:0] udev_req_data;
   logic          udev_req_ready;
   logic          udev_resp_valid;
   logic [CW-1:0] udev_resp_cmd;
   logic [AW-1:0] udev_resp_dstaddr;
   logic [AW-1:0] udev_resp_srcaddr;
   logic [DW-1:0] udev_resp_data;
   logic          udev_resp_ready;

   // Reference model and expected responses
   logic [7:0]    ref_mem [RAMDEPTH*NB];
   logic [CW-1:0] exp_cmd_q [$];
   logic [AW-1:0] exp_dst_q [$];
   logic [AW-1:0] exp_src_q [$];
   logic [DW-1:0] exp_data_q [$];

   integer seed = 33673;
   int     n_issued = 0;
   int     n_checks = 0;
   int     n_errors = 0;
   int     n_resp   = 0;
   logic   bp_mode  = 1'b0; // Random response back-pressure
   logic   ready_on = 1'b0; // Response side stays stalled until set

   tb_clkgen i_tb_clkgen (.clk(clk), .nreset(nreset));

   umi_mem_agent #(
      .DW       (DW),
      .AW       (AW),
      .CW       (CW),
      .RAMDEPTH (RAMDEPTH)
   ) i_umi_mem_agent (
      .clk               (clk),
      .nreset            (nreset),
      .udev_req_valid    (udev_req_valid),
      .udev_req_cmd      (udev_req_cmd),
      .udev_req_dstaddr  (udev_req_dstaddr),
      .udev_req_srcaddr  (udev_req_srcaddr),
      .udev_req_data     (udev_req_data),
      .udev_req_ready    (udev_req_ready),
      .udev_resp_valid   (udev_resp_valid),
      .udev_resp_cmd     (udev_resp_cmd),
      .udev_resp_dstaddr (udev_resp_dstaddr),
      .udev_resp_srcaddr (udev_resp_srcaddr),
      .udev_resp_data    (udev_resp_data),
      .udev_resp_ready   (udev_resp_ready)
   );

   // ##############################
   // Reference model
   // ##############################

   function automatic logic [DW-1:0] rand_data();
      logic [DW-1:0] d;
      for (int i = 0; i < DW/32; i++)
         d[32*i +: 32] = $random(seed);
      return d;
   endfunction

   // Row bytes from the offset up, zero past the row end
   function automatic logic [DW-1:0] ref_read(input logic [AW-1:0] addr);
      logic [DW-1:0] d;
      int            row;
      int            off;
      row = int'(addr[OW +: RW]);
      off = int'(addr[OW-1:0]);
      d   = '0;
      for (int i = 0; i < NB; i++)
         if (off + i < NB)
            d[8*i +: 8] = ref_mem[row*NB + off + i];
      return d;
   endfunction

   task automatic ref_write(input logic [AW-1:0] addr, input int nbytes,
                            input logic [DW-1:0] data);
      int row;
      int off;
      row = int'(addr[OW +: RW]);
      off = int'(addr[OW-1:0]);
      for (int k = 0; k < nbytes; k++)
         ref_mem[row*NB + off + k] = data[8*k +: 8]; // Request byte k to lane off+k
   endtask

   // Same reserved, length and size, new opcode
   function automatic logic [CW-1:0] resp_cmd(input logic [CW-1:0] req, input logic [4:0] op);
      return {req[CW-1:umi_pkg::OPCODE_W], op};
   endfunction

   // Request seen at the accepting edge
   task automatic model_req();
      logic [4:0]    op;
      int            nbytes;
      op     = udev_req_cmd[umi_pkg::OPCODE_LSB +: umi_pkg::OPCODE_W];
      nbytes = (int'(udev_req_cmd[umi_pkg::LEN_LSB +: umi_pkg::LEN_W]) + 1)
               << int'(udev_req_cmd[umi_pkg::SIZE_LSB +: umi_pkg::SIZE_W]);
      if (op == umi_pkg::UMI_REQ_READ || op == umi_pkg::UMI_REQ_WRITE) begin
         exp_dst_q.push_back(udev_req_srcaddr);   // Addresses swap
         exp_src_q.push_back(udev_req_dstaddr);
      end
      if (op == umi_pkg::UMI_REQ_READ) begin
         exp_cmd_q.push_back(resp_cmd(udev_req_cmd, umi_pkg::UMI_RESP_READ));
         exp_data_q.push_back(ref_read(udev_req_dstaddr));
      end else if (op == umi_pkg::UMI_REQ_WRITE) begin
         ref_write(udev_req_dstaddr, nbytes, udev_req_data);
         exp_cmd_q.push_back(resp_cmd(udev_req_cmd, umi_pkg::UMI_RESP_WRITE));
         exp_data_q.push_back('0);
      end else if (op == umi_pkg::UMI_REQ_POSTED) begin
         ref_write(udev_req_dstaddr, nbytes, udev_req_data); // Silent
      end
   endtask

   // ##############################
   // Response compare
   // ##############################

   task automatic check_resp();
      logic [CW-1:0] e_cmd;
      logic [AW-1:0] e_dst;
      logic [AW-1:0] e_src;
      logic [DW-1:0] e_data;
      n_resp++;
      if (exp_cmd_q.size() == 0) begin
         $display("Response arrived while no request was waiting for one");
         n_errors++;
      end else begin
         e_cmd    = exp_cmd_q.pop_front();
         e_dst    = exp_dst_q.pop_front();
         e_src    = exp_src_q.pop_front();
         e_data   = exp_data_q.pop_front();
         n_checks = n_checks + 4;
         if (udev_resp_cmd !== e_cmd) begin
            $display("FAILED udev_resp_cmd: expected %h, got %h", e_cmd, udev_resp_cmd);
            n_errors++;
         end
         if (udev_resp_dstaddr !== e_dst) begin
            $display("FAILED udev_resp_dstaddr: expected %h, got %h", e_dst, udev_resp_dstaddr);
            n_errors++;
         end
         if (udev_resp_srcaddr !== e_src) begin
            $display("FAILED udev_resp_srcaddr: expected %h, got %h", e_src, udev_resp_srcaddr);
            n_errors++;
         end
         if (udev_resp_data !== e_data) begin
            $display("FAILED udev_resp_data: expected %h, got %h", e_data, udev_resp_data);
            n_errors++;
         end
      end
   endtask

   // Handshakes sampled mid-cycle, where everything is settled
   always @(negedge clk) begin
      if (nreset) begin
         if (udev_resp_valid && udev_resp_ready)
            check_resp();  // Older than any request taken now
         if (udev_req_valid && udev_req_ready)
            model_req();
      end
   end

   always @(posedge clk) begin
      #1;
      if (!ready_on)
         udev_resp_ready = 1'b0;              // Stalled through reset
      else if (bp_mode)
         udev_resp_ready = 1'($random(seed)); // Coin flip
      else
         udev_resp_ready = 1'b1;
   end

   // ##############################
   // Stimulus
   // ##############################

   // Called at 1 ns after an edge, returns at the same point
   task automatic send_req(input logic [4:0] op, input int size, input int len,
                           input logic [AW-1:0] addr, input logic [DW-1:0] data);
      logic [63:0] cmd;
      logic [63:0] rsvd;
      rsvd = {32'd0, 16'($random(seed)), 16'd0};
      cmd  = umi_pkg::umi_cmd(op, 3'(size), 8'(len), rsvd);
      n_issued++;
      udev_req_valid   = 1'b1;
      udev_req_cmd     = cmd[CW-1:0];
      udev_req_dstaddr = addr;
      udev_req_srcaddr = {$random(seed), $random(seed)};
      udev_req_data    = data;
      @(negedge clk);
      while (!udev_req_ready)
         @(negedge clk);
      @(posedge clk);
      #1;
      udev_req_valid = 1'b0;
   endtask

   // Random offset, size and length that stay inside the row
   task automatic send_partial(input logic [4:0] op);
      int row;
      int off;
      int size;
      int beats;
      int len;
      row  = $unsigned($random(seed)) % RAMDEPTH;
      off  = $unsigned($random(seed)) % NB;
      size = $unsigned($random(seed)) % (OW + 1);
      while ((NB - off) < (1 << size))
         size--;
      beats = (NB - off) >> size;
      len   = $unsigned($random(seed)) % beats;
      send_req(op, size, len, AW'(row*NB + off), rand_data());
   endtask

   task automatic drain();
      while (exp_cmd_q.size() != 0)
         @(posedge clk);
      repeat (3) @(posedge clk); // Room for a stray response
      #1;
   endtask

   task automatic report_test(input string name, input int err_before);
      $display("Test %s done, %0d errors", name, n_errors - err_before);
   endtask

   initial begin
      int err0;
      int pick;
      udev_req_valid   = 1'b0;
      udev_req_cmd     = '0;
      udev_req_dstaddr = '0;
      udev_req_srcaddr = '0;
      udev_req_data    = '0;
      udev_resp_ready  = 1'b0;
      wait (nreset === 1'b1);
      @(negedge clk);

      // Idle state out of reset, ready must come from the empty slot alone
      err0     = n_errors;
      n_checks = n_checks + 2;
      if (udev_resp_valid !== 1'b0) begin
         $display("FAILED udev_resp_valid: expected 0, got %h", udev_resp_valid);
         n_errors++;
      end
      if (udev_req_ready !== 1'b1) begin
         $display("FAILED udev_req_ready: expected 1, got %h", udev_req_ready);
         n_errors++;
      end
      report_test("reset_state", err0);
      ready_on = 1'b1;
      @(posedge clk);
      #1;

      err0 = n_errors;
      for (int row = 0; row < RAMDEPTH; row++)
         send_req(umi_pkg::UMI_REQ_WRITE, OW, 0, AW'(row*NB), rand_data());
      drain();
      report_test("full_row_write", err0);

      err0 = n_errors;
      for (int row = 0; row < RAMDEPTH; row++)
         send_req(umi_pkg::UMI_REQ_READ, OW, 0, AW'(row*NB), '0);
      drain();
      report_test("full_row_read", err0);

      err0 = n_errors;
      for (int i = 0; i < 150; i++)
         send_partial(($random(seed) & 1) ? umi_pkg::UMI_REQ_WRITE : umi_pkg::UMI_REQ_READ);
      drain();
      report_test("partial", err0);

      // Posted writes, then read everything back
      err0 = n_errors;
      for (int i = 0; i < 40; i++)
         send_partial(umi_pkg::UMI_REQ_POSTED);
      for (int row = 0; row < RAMDEPTH; row++)
         send_req(umi_pkg::UMI_REQ_READ, OW, 0, AW'(row*NB), '0);
      drain();
      report_test("posted", err0);

      err0    = n_errors;
      bp_mode = 1'b1;
      for (int i = 0; i < 300; i++) begin
         pick = $unsigned($random(seed)) % 3;
         if (pick == 0)
            send_partial(umi_pkg::UMI_REQ_READ);
         else if (pick == 1)
            send_partial(umi_pkg::UMI_REQ_WRITE);
         else
            send_partial(umi_pkg::UMI_REQ_POSTED);
      end
      drain();
      bp_mode = 1'b0;
      report_test("backpressure", err0);

      $display("Requests: %0d, responses: %0d, checks: %0d, errors: %0d",
               n_issued, n_resp, n_checks, n_errors);
      if (n_errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

   // Limit grows with every request issued
   initial begin
      int cycles;
      cycles = 0;
      while (cycles <= 200*n_issued + MARGIN) begin
         @(posedge clk);
         cycles++;
      end
      $display("Watchdog expired after %0d cycles with %0d requests issued", cycles, n_issued);
      $display("Something failed");
      $finish;
   end

endmodule

// ==== tb_clkgen.sv ====
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clkgen #(
   parameter real PERIOD     = 4.0, // Clock period in ns
   parameter int  RST_CYCLES = 2    // Cycles held in reset
) (
   output logic clk,
   output logic nreset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   initial begin
      nreset = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      nreset = 1'b1; // Released away from the edge
   end

endmodule

// ==== umi_mem_agent.sv ====
// UMI memory agent
`timescale 1ns/10ps

module umi_mem_agent #(
   parameter DW       = 256, // Data width
   parameter AW       = 64,  // Address width
   parameter CW       = 32,  // Command width
   parameter RAMDEPTH = 512  // Rows
) (
   input  logic          clk,
   input  logic          nreset,
   // Request channel
   input  logic          udev_req_valid,
   input  logic [CW-1:0] udev_req_cmd,
   input  logic [AW-1:0] udev_req_dstaddr,
   input  logic [AW-1:0] udev_req_srcaddr,
   input  logic [DW-1:0] udev_req_data,
   output logic          udev_req_ready,
   // Response channel
   output logic          udev_resp_valid,
   output logic [CW-1:0] udev_resp_cmd,
   output logic [AW-1:0] udev_resp_dstaddr,
   output logic [AW-1:0] udev_resp_srcaddr,
   output logic [DW-1:0] udev_resp_data,
   input  logic          udev_resp_ready
);

   localparam int NB  = DW/8;              // Byte lanes per row
   localparam int OW  = $clog2(NB);        // Byte offset bits
   localparam int RAW = $clog2(RAMDEPTH);  // Row address bits

   // Endpoint side
   logic [AW-1:0]              loc_addr;
   logic                       loc_write;
   logic                       loc_read;
   logic [umi_pkg::SIZE_W-1:0] loc_size;
   logic [umi_pkg::LEN_W-1:0]  loc_len;
   logic [DW-1:0]              loc_wrdata;
   logic [DW-1:0]              loc_rddata;

   // Byte placement
   logic [OW-1:0]              wr_off;
   logic [OW-1:0]              rd_off_q;  // Offset of the read in flight
   logic [15:0]                len_p1;
   logic [15:0]                num_bytes;
   logic [16:0]                lane_end;  // One past the last byte lane
   logic [DW-1:0]              wmask;
   logic [DW-1:0]              wr_data;

   // RAM side
   logic                       ram_ce;
   logic [RAW-1:0]             ram_addr;
   logic [DW-1:0]              mem_rddata;

   // ############################
   // Endpoint
   // ############################

   umi_endpoint #(
      .DW (DW),
      .AW (AW),
      .CW (CW)
   ) i_umi_endpoint (
      .clk               (clk),
      .nreset            (nreset),
      .udev_req_valid    (udev_req_valid),
      .udev_req_cmd      (udev_req_cmd),
      .udev_req_dstaddr  (udev_req_dstaddr),
      .udev_req_srcaddr  (udev_req_srcaddr),
      .udev_req_data     (udev_req_data),
      .udev_req_ready    (udev_req_ready),
      .udev_resp_valid   (udev_resp_valid),
      .udev_resp_cmd     (udev_resp_cmd),
      .udev_resp_dstaddr (udev_resp_dstaddr),
      .udev_resp_srcaddr (udev_resp_srcaddr),
      .udev_resp_data    (udev_resp_data),
      .udev_resp_ready   (udev_resp_ready),
      .loc_addr          (loc_addr),
      .loc_write         (loc_write),
      .loc_read          (loc_read),
      .loc_size          (loc_size),
      .loc_len           (loc_len),
      .loc_wrdata        (loc_wrdata),
      .loc_rddata        (loc_rddata)
   );

   // ############################
   // Byte mask and alignment
   // ############################

   assign wr_off    = loc_addr[OW-1:0];
   assign ram_addr  = loc_addr[OW +: RAW];              // Row above the offset
   assign len_p1    = {8'd0, loc_len} + 16'd1;          // Beats
   assign num_bytes = len_p1 << loc_size;               // Beats times beat bytes
   assign lane_end  = {{(17-OW){1'b0}}, wr_off} + {1'b0, num_bytes};

   // Lanes from offset up to offset plus count
   always_comb begin
      for (int i = 0; i < NB; i++) begin
         if ((17'(i) >= 17'(wr_off)) && (17'(i) < lane_end))
            wmask[8*i +: 8] = 8'hFF;
         else
            wmask[8*i +: 8] = 8'h00;
      end
   end

   assign wr_data = loc_wrdata << {wr_off, 3'b000}; // Up to the first lane
   assign ram_ce  = loc_read | loc_write;

   // Offset follows the RAM read by one cycle
   always_ff @(posedge clk) begin
      if (ram_ce)
         rd_off_q <= wr_off;
   end

   assign loc_rddata = mem_rddata >> {rd_off_q, 3'b000}; // First byte to lane 0

   // ############################
   // Memory
   // ############################

   la_spram #(
      .DW (DW),
      .AW (RAW)
   ) i_la_spram (
      .clk   (clk),
      .ce    (ram_ce),
      .we    (loc_write),
      .wmask (wmask),
      .addr  (ram_addr),
      .din   (wr_data),
      .dout  (mem_rddata)
   );

endmodule

// ==== la_spram.sv ====
// Behavioral single-port RAM
`timescale 1ns/10ps

module la_spram #(
   parameter DW = 256, // Row width in bits
   parameter AW = 9    // Row address width
) (
   input  logic          clk,
   input  logic          ce,    // Chip enable
   input  logic          we,    // Write enable
   input  logic [DW-1:0] wmask, // Per-bit write enable
   input  logic [AW-1:0] addr,
   input  logic [DW-1:0] din,
   output logic [DW-1:0] dout
);

   localparam int DEPTH = 2**AW;

   logic [DW-1:0] mem [DEPTH];
   logic [DW-1:0] row_old;
   logic [DW-1:0] row_new;

   // Merge incoming bits into the addressed row
   assign row_old = mem[addr];
   assign row_new = (row_old & ~wmask) | (din & wmask);

   // Array update
   always_ff @(posedge clk) begin
      if (ce && we)
         mem[addr] <= row_new;
   end

   // Registered read, old data on a write
   always_ff @(posedge clk) begin
      if (ce)
         dout <= row_old;
   end

endmodule

// ==== umi_endpoint.sv ====
// UMI device endpoint
`timescale 1ns/10ps

module umi_endpoint #(
   parameter DW = 256, // Data width
   parameter AW = 64,  // Address width
   parameter CW = 32   // Command width
) (
   input  logic                        clk,
   input  logic                        nreset,
   // Request channel
   input  logic                        udev_req_valid,
   input  logic [CW-1:0]               udev_req_cmd,
   input  logic [AW-1:0]               udev_req_dstaddr,
   input  logic [AW-1:0]               udev_req_srcaddr,
   input  logic [DW-1:0]               udev_req_data,
   output logic                        udev_req_ready,
   // Response channel
   output logic                        udev_resp_valid,
   output logic [CW-1:0]               udev_resp_cmd,
   output logic [AW-1:0]               udev_resp_dstaddr,
   output logic [AW-1:0]               udev_resp_srcaddr,
   output logic [DW-1:0]               udev_resp_data,
   input  logic                        udev_resp_ready,
   // Local memory side
   output logic [AW-1:0]               loc_addr,
   output logic                        loc_write,
   output logic                        loc_read,
   output logic [umi_pkg::SIZE_W-1:0]  loc_size,
   output logic [umi_pkg::LEN_W-1:0]   loc_len,
   output logic [DW-1:0]               loc_wrdata,
   input  logic [DW-1:0]               loc_rddata
);

   localparam int XW = umi_pkg::CMD_MAXW; // Helper command width

   // Decode
   logic [umi_pkg::OPCODE_W-1:0] req_opcode;
   logic [umi_pkg::SIZE_W-1:0]   req_size;
   logic [umi_pkg::LEN_W-1:0]    req_len;
   logic                         req_accept;
   logic                         is_read;
   logic                         is_write;
   logic                         is_ack;
   logic                         needs_resp;

   // Response build
   logic [umi_pkg::OPCODE_W-1:0] resp_opcode;
   logic [XW-1:0]                req_cmd_ext;
   logic [XW-1:0]                resp_cmd_ext;

   // Response register
   logic                         resp_valid_q;
   logic                         data_pend_q;  // RAM data lands this cycle
   logic [CW-1:0]                resp_cmd_q;
   logic [AW-1:0]                resp_dst_q;
   logic [AW-1:0]                resp_src_q;
   logic [DW-1:0]                resp_data_q;

   // ############################
   // Request decode
   // ############################

   assign req_opcode = udev_req_cmd[umi_pkg::OPCODE_LSB +: umi_pkg::OPCODE_W];
   assign req_size   = udev_req_cmd[umi_pkg::SIZE_LSB +: umi_pkg::SIZE_W];
   assign req_len    = udev_req_cmd[umi_pkg::LEN_LSB +: umi_pkg::LEN_W];

   assign is_read    = (req_opcode == umi_pkg::UMI_REQ_READ);
   assign is_ack     = (req_opcode == umi_pkg::UMI_REQ_WRITE);
   assign is_write   = is_ack | (req_opcode == umi_pkg::UMI_REQ_POSTED); // Both write kinds
   assign needs_resp = is_read | is_ack;  // Posted writes stay silent

   // Slot free, or emptied this very cycle
   assign udev_req_ready = ~resp_valid_q | udev_resp_ready;
   assign req_accept     = udev_req_valid & udev_req_ready;

   // Memory side strobes only on a real transfer
   assign loc_read   = req_accept & is_read;
   assign loc_write  = req_accept & is_write;
   assign loc_addr   = udev_req_dstaddr;
   assign loc_size   = req_size;
   assign loc_len    = req_len;
   assign loc_wrdata = udev_req_data;

   // ############################
   // Response command
   // ############################

   assign resp_opcode = is_read ? umi_pkg::UMI_RESP_READ : umi_pkg::UMI_RESP_WRITE;

   // Widen request command so reserved bits pass through the helper
   always_comb begin
      req_cmd_ext         = '0;
      req_cmd_ext[CW-1:0] = udev_req_cmd;
   end

   assign resp_cmd_ext = umi_pkg::umi_cmd(resp_opcode, req_size, req_len, req_cmd_ext);

   // ############################
   // Response register
   // ############################

   // Control state
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         resp_valid_q <= 1'b0;
         data_pend_q  <= 1'b0;
      end else begin
         if (req_accept && needs_resp)
            resp_valid_q <= 1'b1;      // New response replaces the taken one
         else if (udev_resp_ready)
            resp_valid_q <= 1'b0;      // Drained
         data_pend_q <= loc_read;      // One cycle after a read accept
      end
   end

   // Header payload, loaded at accept
   always_ff @(posedge clk) begin
      if (req_accept && needs_resp) begin
         resp_cmd_q <= resp_cmd_ext[CW-1:0];
         resp_dst_q <= udev_req_srcaddr; // Back to the requester
         resp_src_q <= udev_req_dstaddr;
      end
   end

   // Data payload
   // Ack load wins; it only coincides with a capture whose response is leaving
   always_ff @(posedge clk) begin
      if (req_accept && is_ack)
         resp_data_q <= '0;            // Write ack carries no data
      else if (data_pend_q)
         resp_data_q <= loc_rddata;    // Freeze RAM data for back-pressure
   end

   // ############################
   // Response outputs
   // ############################

   assign udev_resp_valid   = resp_valid_q;
   assign udev_resp_cmd     = resp_cmd_q;
   assign udev_resp_dstaddr = resp_dst_q;
   assign udev_resp_srcaddr = resp_src_q;

   // RAM output is live in the first response cycle, held copy after
   assign udev_resp_data    = data_pend_q ? loc_rddata : resp_data_q;

endmodule

// ==== umi_pkg.sv ====
// UMI protocol definitions
package umi_pkg;

   // ############################
   // Opcodes
   // ############################
   localparam logic [4:0] UMI_REQ_READ   = 5'd1; // Read request
   localparam logic [4:0] UMI_RESP_READ  = 5'd2; // Read response with data
   localparam logic [4:0] UMI_REQ_WRITE  = 5'd3; // Write, acknowledged
   localparam logic [4:0] UMI_RESP_WRITE = 5'd4; // Write acknowledge
   localparam logic [4:0] UMI_REQ_POSTED = 5'd5; // Write, no response

   // ############################
   // Command layout
   // ############################
   localparam int OPCODE_LSB = 0;
   localparam int OPCODE_W   = 5;
   localparam int SIZE_LSB   = 5;  // log2 of bytes per beat
   localparam int SIZE_W     = 3;
   localparam int LEN_LSB    = 8;  // Beats minus one
   localparam int LEN_W      = 8;
   localparam int RSVD_LSB   = 16; // Carried through to the response

   // Widest command the helper packs, CW must not exceed this
   localparam int CMD_MAXW   = 64;

   // Packs opcode, size and length over the reserved bits of rsvd
   function automatic logic [CMD_MAXW-1:0] umi_cmd(
      input logic [OPCODE_W-1:0] opcode,
      input logic [SIZE_W-1:0]   size,
      input logic [LEN_W-1:0]    len,
      input logic [CMD_MAXW-1:0] rsvd
   );
      logic [CMD_MAXW-1:0] cmd;
      cmd = '0;
      cmd[CMD_MAXW-1:RSVD_LSB]      = rsvd[CMD_MAXW-1:RSVD_LSB]; // Upper bits untouched
      cmd[OPCODE_LSB +: OPCODE_W]   = opcode;
      cmd[SIZE_LSB +: SIZE_W]       = size;
      cmd[LEN_LSB +: LEN_W]         = len;
      return cmd;
   endfunction

endpackage
